// ==== tcb_macros.svh ====
////////////////////////////////////////
// tcb bus sizing
// data width, byte count, offset and
// byte address width of the subsystem
////////////////////////////////////////

`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

// data bus width in bits
`define TCB_DAT_W 32

// bytes per data word
`define TCB_BYT 4

// byte offset inside a word
`define TCB_OFF_W 2

// byte address width, 256 words of memory
// (word address is what remains above the offset)
`define TCB_ADR_W 10

`endif

// ==== tcb_pkg.sv ====
////////////////////////////////////////
// tcb package
// bus vector types, endianness and the
// request and response structs
////////////////////////////////////////

package tcb_pkg;

`include "tcb_macros.svh"

////////////////////////////////////////
// vector types
////////////////////////////////////////

    // byte address
    typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

    // byte offset inside word
    typedef logic [`TCB_OFF_W-1:0] tcb_off_t;

    // log size code, 0 byte, 1 half, 2 word
    typedef logic [1:0] tcb_siz_t;

    // data word
    typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

    // byte enables, one per lane
    typedef logic [`TCB_BYT-1:0] tcb_byt_t;

    // endianness of the item
    typedef enum logic {
        TCB_LITTLE = 1'b0,
        TCB_BIG    = 1'b1
    } tcb_ndn_t;

////////////////////////////////////////
// structs
////////////////////////////////////////

    // log size request, wdt packed from byte 0
    typedef struct packed {
        logic     ren;
        logic     wen;
        tcb_ndn_t ndn;
        tcb_siz_t siz;
        tcb_adr_t adr;
        tcb_dat_t wdt;
    } tcb_req_t;

    // byte enable request, wdt on its lanes
    typedef struct packed {
        logic                             ren;
        logic                             wen;
        logic [`TCB_ADR_W-`TCB_OFF_W-1:0] wad;
        tcb_byt_t                         byt;
        tcb_dat_t                         wdt;
    } tcb_mem_req_t;

    // response
    typedef struct packed {
        tcb_dat_t rdt;
        logic     sts;
    } tcb_rsp_t;

endpackage

// ==== tcb_logsize2byteena.sv ====
////////////////////////////////////////
// tcb log size to byte enable decode
// byte enables from offset and size,
// write lane steering per endianness,
// illegal request detection
////////////////////////////////////////

`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_logsize2byteena (
    input  logic                  vld,
    input  tcb_pkg::tcb_req_t     req,
    output tcb_pkg::tcb_mem_req_t mem_req,
    output tcb_pkg::tcb_off_t     off,
    output tcb_pkg::tcb_siz_t     siz,
    output tcb_pkg::tcb_ndn_t     ndn,
    output logic                  err
);

////////////////////////////////////////
// local signals
////////////////////////////////////////

    // item byte mask, not yet rotated
    tcb_pkg::tcb_byt_t len_msk;

    // item byte index seen by each lane
    tcb_pkg::tcb_off_t idx_lit [`TCB_BYT];
    tcb_pkg::tcb_off_t idx_big [`TCB_BYT];

    // first byte past the access
    int span;

    // size 3 or crossing the word end
    logic bad;

    // request attributes, also kept by the result stage
    assign off = req.adr[`TCB_OFF_W-1:0];
    assign siz = req.siz;
    assign ndn = req.ndn;

////////////////////////////////////////
// legality
////////////////////////////////////////

    assign span = int'(off) + (1 << siz);
    assign bad  = (siz == 2'd3) || (span > `TCB_BYT);

    // only a real request reports an error
    assign err = vld & bad;

////////////////////////////////////////
// lane mapping
////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `TCB_BYT; i++) begin
            // ones for item bytes below 2^siz
            len_msk[i] = (i < (1 << siz));
            // little endian, lane offset+k holds byte k
            idx_lit[i] = tcb_pkg::tcb_off_t'(i - int'(off));
            // big endian, reversed inside the item
            idx_big[i] = tcb_pkg::tcb_off_t'((1 << siz) - 1 - i + int'(off));
        end
    end

////////////////////////////////////////
// byte enable request
////////////////////////////////////////

    always_comb begin
        // illegal access never reaches the memory
        mem_req.ren = req.ren & ~bad;
        mem_req.wen = req.wen & ~bad;
        mem_req.wad = req.adr[`TCB_ADR_W-1:`TCB_OFF_W];
        for (int i = 0; i < `TCB_BYT; i++) begin
            // mask rotated by offset
            mem_req.byt[i] = len_msk[idx_lit[i]] & ~bad;
            // write byte steering
            if (ndn == tcb_pkg::TCB_BIG) begin
                mem_req.wdt[8*i +: 8] = req.wdt[8*idx_big[i] +: 8];
            end else begin
                mem_req.wdt[8*i +: 8] = req.wdt[8*idx_lit[i] +: 8];
            end
        end
    end

endmodule

// ==== tcb_mem.sv ====
////////////////////////////////////////
// tcb byte enable memory
// 256 words, byte write enables,
// read data registered one cycle
////////////////////////////////////////

`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_mem (
    input  logic                  clk,
    input  tcb_pkg::tcb_mem_req_t mem_req,
    input  logic                  vld,
    output tcb_pkg::tcb_dat_t     rdt
);

////////////////////////////////////////
// storage
////////////////////////////////////////

    // one entry per word address
    tcb_pkg::tcb_dat_t mem [2**(`TCB_ADR_W-`TCB_OFF_W)];

    // qualified accesses
    logic wr;
    logic rd;

    assign wr = vld & mem_req.wen;
    assign rd = vld & mem_req.ren;

////////////////////////////////////////
// write
////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr) begin
            // only enabled lanes change,
            // the rest of the word keeps its value
            for (int i = 0; i < `TCB_BYT; i++) begin
                if (mem_req.byt[i]) begin
                    mem[mem_req.wad][8*i +: 8] <= mem_req.wdt[8*i +: 8];
                end
            end
        end
    end

////////////////////////////////////////
// read
////////////////////////////////////////

    // whole word, lanes sorted out in the result stage
    // read during write of the same word returns old data
    always_ff @(posedge clk) begin
        if (rd) begin
            rdt <= mem[mem_req.wad];
        end
    end

endmodule

// ==== tcb_rsp_align.sv ====
////////////////////////////////////////
// tcb response realignment
// delays request attributes to meet the
// read data, returns lanes to item order
////////////////////////////////////////

`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_rsp_align (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              vld,
    input  tcb_pkg::tcb_off_t off,
    input  tcb_pkg::tcb_siz_t siz,
    input  tcb_pkg::tcb_ndn_t ndn,
    input  logic              ren,
    input  logic              err,
    input  tcb_pkg::tcb_dat_t rdt,
    output logic              rsp_vld,
    output tcb_pkg::tcb_rsp_t rsp
);

    // attributes delayed by one cycle
    logic              vld_q;
    logic              ren_q;
    logic              err_q;
    tcb_pkg::tcb_off_t off_q;
    tcb_pkg::tcb_siz_t siz_q;
    tcb_pkg::tcb_ndn_t ndn_q;

    // memory lane holding each item byte
    tcb_pkg::tcb_off_t lane [`TCB_BYT];

    // realigned and masked read data
    tcb_pkg::tcb_dat_t rdt_aln;

////////////////////////////////////////
// delay stage
////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= 1'b0;
            ren_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            vld_q <= vld;
            if (vld) begin
                ren_q <= ren;
                err_q <= err;
            end
        end
    end

    // item attributes
    always_ff @(posedge clk) begin
        if (vld) begin
            off_q <= off;
            siz_q <= siz;
            ndn_q <= ndn;
        end
    end

////////////////////////////////////////
// realignment
////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `TCB_BYT; k++) begin
            // inverse of the decode lane rule
            if (ndn_q == tcb_pkg::TCB_BIG) begin
                lane[k] = tcb_pkg::tcb_off_t'((1 << siz_q) - 1 - k + int'(off_q));
            end else begin
                lane[k] = tcb_pkg::tcb_off_t'(k + int'(off_q));
            end
            // bytes at and above 2^siz are zero
            rdt_aln[8*k +: 8] = (k < (1 << siz_q)) ? rdt[8*lane[k] +: 8] : 8'h00;
        end
    end

    // writes and blocked requests return zero data
    assign rsp_vld = vld_q;
    assign rsp.rdt = ren_q ? rdt_aln : '0;
    assign rsp.sts = err_q;

endmodule

// ==== tcb_sys.sv ====
////////////////////////////////////////
// tcb subsystem top
// log size manager port on a byte
// enable memory, one cycle response
////////////////////////////////////////

`timescale 1ns/1ps

module tcb_sys (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rsp_vld,
    output tcb_pkg::tcb_rsp_t rsp
);

    // decode to execute
    tcb_pkg::tcb_mem_req_t mem_req;

    // decode to result, request attributes
    tcb_pkg::tcb_off_t off;
    tcb_pkg::tcb_siz_t siz;
    tcb_pkg::tcb_ndn_t ndn;
    logic              err;

    // execute to result
    tcb_pkg::tcb_dat_t rdt;

    // decode
    tcb_logsize2byteena u_dec (
        .vld     (vld),
        .req     (req),
        .mem_req (mem_req),
        .off     (off),
        .siz     (siz),
        .ndn     (ndn),
        .err     (err)
    );

    // execute
    tcb_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .vld     (vld),
        .rdt     (rdt)
    );

    // result, ren already cleared for illegal requests
    tcb_rsp_align u_rsp (
        .clk     (clk),
        .arst_n  (arst_n),
        .vld     (vld),
        .off     (off),
        .siz     (siz),
        .ndn     (ndn),
        .ren     (mem_req.ren),
        .err     (err),
        .rdt     (rdt),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

endmodule

// ==== tcb_sys_tb.sv ====
////////////////////////////////////////
// tcb subsystem testbench
// directed tests against a byte level
// model of the memory, in order checks
////////////////////////////////////////

`timescale 1ns/1ps
`include "tcb_macros.svh"

module tcb_sys_tb;

    // clock period in ns
    localparam int PERIOD = 100;
    localparam int RST_CYC = 16;
    // requests over all tests, 16 + 16 + 10 + 32 + 8
    localparam int N_REQ = 82;
    // two periods per request, reset, margin
    localparam int WDOG_CYC = 2*N_REQ + RST_CYC + 20;

    // expected response and the cycle its request was driven
    typedef struct packed {
        tcb_pkg::tcb_rsp_t rsp;
        int                cyc;
    } exp_t;

    logic              clk;
    logic              arst_n;
    logic              vld;
    tcb_pkg::tcb_req_t req;
    logic              rsp_vld;
    tcb_pkg::tcb_rsp_t rsp;

    // byte model of the memory
    logic [7:0]  model [2**`TCB_ADR_W];
    exp_t        exp_q [$];
    logic [31:0] rnd_state = 32'h00fb_9064;
    int          cyc;
    int          errors;
    int          test_err;
    int          n_checked;

    tcb_sys u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .vld     (vld),
        .req     (req),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // hung run
    initial begin
        #(WDOG_CYC*PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", WDOG_CYC);
        $display("Checks failed");
        $finish;
    end

////////////////////////////////////////
// helpers
////////////////////////////////////////

    function automatic logic [31:0] rand_next();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state;
    endfunction

    // known byte per address, uses all address bits
    function automatic logic [7:0] fill_byte(input tcb_pkg::tcb_adr_t a);
        return a[7:0] ^ {a[9:8], 6'h15};
    endfunction

    task automatic check_rdt(input tcb_pkg::tcb_dat_t got, input tcb_pkg::tcb_dat_t exp);
        n_checked++;
        if (got !== exp) begin
            $display("** Error at %0d ns: rdt is %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_sts(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: sts is %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    // response of the request driven one cycle back
    task automatic sample_rsp();
        exp_t e;
        if (rsp_vld === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("at %0d ns rsp_vld was high with no request outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_rdt(rsp.rdt, e.rsp.rdt);
                check_sts(rsp.sts, e.rsp.sts);
            end
        end else begin
            if (rsp_vld !== 1'b0) begin
                $display("at %0d ns rsp_vld is unknown", $time);
                errors++;
            end
            if (exp_q.size() != 0 && exp_q[0].cyc < cyc) begin
                $display("at %0d ns rsp_vld did not come one cycle after the request", $time);
                errors++;
                exp_q.delete(0);
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        sample_rsp();
    endtask

    task automatic idle();
        next_cycle();
        vld = 1'b0;
        req = '0;
    endtask

    // drive one request, model its effect and expected response
    task automatic issue(input logic ren, input logic wen, input tcb_pkg::tcb_ndn_t ndn,
                         input tcb_pkg::tcb_siz_t siz, input tcb_pkg::tcb_adr_t adr,
                         input tcb_pkg::tcb_dat_t wdt);
        exp_t e;
        int   n;
        int   off;
        int   base;
        int   lane;
        logic legal;
        n     = 1 << siz;
        off   = int'(adr[1:0]);
        base  = int'(adr) - off;
        legal = (siz != 2'd3) && (off + n <= 4);
        e.rsp.rdt = '0;
        e.rsp.sts = ~legal;
        if (legal) begin
            for (int k = 0; k < n; k++) begin
                // lane of item byte k
                lane = (ndn == tcb_pkg::TCB_BIG) ? off + n - 1 - k : off + k;
                if (wen) begin
                    model[base + lane] = wdt[8*k +: 8];
                end else if (ren) begin
                    e.rsp.rdt[8*k +: 8] = model[base + lane];
                end
            end
        end
        next_cycle();
        e.cyc   = cyc;
        vld     = 1'b1;
        req.ren = ren;
        req.wen = wen;
        req.ndn = ndn;
        req.siz = siz;
        req.adr = adr;
        req.wdt = wdt;
        exp_q.push_back(e);
    endtask

    task automatic write_item(input tcb_pkg::tcb_ndn_t ndn, input tcb_pkg::tcb_siz_t siz,
                              input tcb_pkg::tcb_adr_t adr, input tcb_pkg::tcb_dat_t wdt);
        issue(1'b0, 1'b1, ndn, siz, adr, wdt);
    endtask

    task automatic read_item(input tcb_pkg::tcb_ndn_t ndn, input tcb_pkg::tcb_siz_t siz,
                             input tcb_pkg::tcb_adr_t adr);
        issue(1'b1, 1'b0, ndn, siz, adr, '0);
    endtask

    // adr word aligned
    task automatic fill_word(input tcb_pkg::tcb_adr_t adr);
        tcb_pkg::tcb_dat_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = fill_byte(tcb_pkg::tcb_adr_t'(adr + i));
        end
        write_item(tcb_pkg::TCB_LITTLE, 2'd2, adr, w);
    endtask

    // drain the pipe, one line per test
    task automatic end_test(input string name);
        idle();
        idle();
        if (errors == test_err) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_err);
        end
        test_err = errors;
    endtask

////////////////////////////////////////
// tests
////////////////////////////////////////

    task automatic test_reset_idle();
        check_sts(rsp.sts, 1'b0);
        for (int i = 0; i < 4; i++) begin
            idle();
        end
        end_test("idle after reset");
    endtask

    // every legal size and offset, read back little endian
    task automatic test_sizes(input tcb_pkg::tcb_ndn_t wr_ndn, input string name);
        tcb_pkg::tcb_adr_t adr;
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o + (1 << s) <= 4; o++) begin
                adr = tcb_pkg::tcb_adr_t'(rand_next() >> 12);
                adr[1:0] = o[1:0];
                write_item(wr_ndn, s[1:0], adr, rand_next());
                read_item(tcb_pkg::TCB_LITTLE, s[1:0], adr);
            end
        end
        end_test(name);
    endtask

    // neighbour lanes keep the fill pattern
    task automatic test_byte_merge();
        tcb_pkg::tcb_adr_t adr;
        adr = 10'h1f0;
        fill_word(adr);
        read_item(tcb_pkg::TCB_LITTLE, 2'd2, adr);
        for (int o = 0; o < 4; o++) begin
            write_item(tcb_pkg::TCB_LITTLE, 2'd0, tcb_pkg::tcb_adr_t'(adr + o), rand_next());
            read_item(tcb_pkg::TCB_LITTLE, 2'd2, adr);
        end
        end_test("byte merge");
    endtask

    // one read per cycle inside a filled region
    task automatic test_b2b_reads();
        logic [31:0]       r;
        tcb_pkg::tcb_siz_t siz;
        int                n;
        int                o;
        for (int w = 0; w < 8; w++) begin
            fill_word(tcb_pkg::tcb_adr_t'(10'h100 + 4*w));
        end
        for (int i = 0; i < 24; i++) begin
            r   = rand_next();
            siz = tcb_pkg::tcb_siz_t'(r[1:0] % 3);
            n   = 1 << siz;
            o   = int'(r[9:8]) % (5 - n);
            read_item(tcb_pkg::tcb_ndn_t'(r[16]), siz,
                      tcb_pkg::tcb_adr_t'(10'h100 + 4*r[14:12] + o));
        end
        end_test("back to back reads");
    endtask

    // word crossing and size 3 are blocked
    task automatic test_illegal();
        tcb_pkg::tcb_adr_t adr;
        adr = 10'h2c0;
        fill_word(adr);
        write_item(tcb_pkg::TCB_LITTLE, 2'd1, tcb_pkg::tcb_adr_t'(adr + 3), rand_next());
        write_item(tcb_pkg::TCB_LITTLE, 2'd2, tcb_pkg::tcb_adr_t'(adr + 2), rand_next());
        write_item(tcb_pkg::TCB_LITTLE, 2'd3, adr, rand_next());
        read_item(tcb_pkg::TCB_LITTLE, 2'd1, tcb_pkg::tcb_adr_t'(adr + 3));
        read_item(tcb_pkg::TCB_BIG, 2'd2, tcb_pkg::tcb_adr_t'(adr + 2));
        read_item(tcb_pkg::TCB_LITTLE, 2'd3, adr);
        read_item(tcb_pkg::TCB_LITTLE, 2'd2, adr);
        end_test("illegal requests");
    endtask

////////////////////////////////////////
// sequence
////////////////////////////////////////

    initial begin
        arst_n    = 1'b0;
        vld       = 1'b0;
        req       = '0;
        cyc       = 0;
        errors    = 0;
        test_err  = 0;
        n_checked = 0;
        repeat (RST_CYC) begin
            @(negedge clk);
        end
        arst_n = 1'b1;
        test_reset_idle();
        test_sizes(tcb_pkg::TCB_LITTLE, "little endian sizes");
        test_sizes(tcb_pkg::TCB_BIG, "big endian writes");
        test_byte_merge();
        test_b2b_reads();
        test_illegal();
        $display("tests 6, responses %0d, errors %0d", n_checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tcb_sys.f ====
+incdir+.
tcb_pkg.sv
tcb_logsize2byteena.sv
tcb_mem.sv
tcb_rsp_align.sv
tcb_sys.sv
tcb_sys_tb.sv
